/* pss_pkg.sv */
package pss_pkg;

    // --------------------------------------------------
    // datapath sizes
    // --------------------------------------------------
    // width of one I or Q component, signed
    localparam int SAMPLE_W = 8;
    localparam int PSS_LEN  = 16;
    localparam int NUM_NID2 = 3;
    // |sum I| + |sum Q|, worst case 2 * 16 * 128
    localparam int MAG_W    = 13;

    // --------------------------------------------------
    // local sequences
    // --------------------------------------------------
    // bit k set -> tap k is +1, clear -> -1
    // tap 0 multiplies the newest sample
    localparam logic [PSS_LEN-1:0] PSS_TAPS_0 = 16'hE8B3;
    localparam logic [PSS_LEN-1:0] PSS_TAPS_1 = 16'h4F1A;
    localparam logic [PSS_LEN-1:0] PSS_TAPS_2 = 16'h7294;

    // --------------------------------------------------
    // operating modes
    // --------------------------------------------------
    localparam logic [1:0] MODE_SEARCH = 2'd0;
    // search limited to the requested N_id_2
    localparam logic [1:0] MODE_FIND   = 2'd1;
    // correlators frozen, code 3 acts the same
    localparam logic [1:0] MODE_PAUSE  = 2'd2;

    // --------------------------------------------------
    // register map
    // --------------------------------------------------
    localparam int APB_ADDR_W = 4;

    // mode [1:0], requested N_id_2 [3:2]
    localparam logic [APB_ADDR_W-1:0] ADDR_CTRL   = 4'h0;
    // detection threshold [12:0]
    localparam logic [APB_ADDR_W-1:0] ADDR_THRESH = 4'h4;
    // last N_id_2 [1:0], detection count [23:8], read only
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 4'h8;
    // last peak magnitude [12:0], read only
    localparam logic [APB_ADDR_W-1:0] ADDR_PEAK   = 4'hC;

endpackage

/* pss_correlator.sv */
`timescale 1ns/100ps

module pss_correlator #(
    parameter logic [pss_pkg::PSS_LEN-1:0] TAPS = pss_pkg::PSS_TAPS_0
) (
    input  logic                                clk_i,
    input  logic                                reset_ni,
    input  logic                                en_i,
    input  logic                                sample_valid_i,
    input  logic signed [pss_pkg::SAMPLE_W-1:0] sample_i_i,
    input  logic signed [pss_pkg::SAMPLE_W-1:0] sample_q_i,
    output logic        [pss_pkg::MAG_W-1:0]    mag_o,
    output logic                                mag_valid_o
);

    // room for the sum of PSS_LEN signed samples
    localparam int SUM_W = pss_pkg::SAMPLE_W + $clog2(pss_pkg::PSS_LEN) + 1;

    logic accept;

    // the PSS_LEN-1 previous samples, index 0 is the most recent one
    logic signed [pss_pkg::SAMPLE_W-1:0] hist_i [pss_pkg::PSS_LEN-1];
    logic signed [pss_pkg::SAMPLE_W-1:0] hist_q [pss_pkg::PSS_LEN-1];

    // full correlation window, newest sample at index 0
    logic signed [pss_pkg::SAMPLE_W-1:0] win_i [pss_pkg::PSS_LEN];
    logic signed [pss_pkg::SAMPLE_W-1:0] win_q [pss_pkg::PSS_LEN];

    logic signed [SUM_W-1:0]         sum_i;
    logic signed [SUM_W-1:0]         sum_q;
    logic        [pss_pkg::MAG_W-1:0] abs_i;
    logic        [pss_pkg::MAG_W-1:0] abs_q;

    assign accept = sample_valid_i && en_i;

    always_comb begin
        win_i[0] = sample_i_i;
        win_q[0] = sample_q_i;
        for (int k = 1; k < pss_pkg::PSS_LEN; k++) begin
            win_i[k] = hist_i[k-1];
            win_q[k] = hist_q[k-1];
        end
    end

    // --------------------------------------------------
    // +-1 correlation, tap sign picks add or subtract
    // --------------------------------------------------
    always_comb begin
        sum_i = '0;
        sum_q = '0;
        for (int k = 0; k < pss_pkg::PSS_LEN; k++) begin
            if (TAPS[k]) begin
                sum_i = sum_i + win_i[k];
                sum_q = sum_q + win_q[k];
            end else begin
                sum_i = sum_i - win_i[k];
                sum_q = sum_q - win_q[k];
            end
        end
    end

    // magnitude estimate |Re| + |Im|
    assign abs_i = pss_pkg::MAG_W'(sum_i[SUM_W-1] ? -sum_i : sum_i);
    assign abs_q = pss_pkg::MAG_W'(sum_q[SUM_W-1] ? -sum_q : sum_q);

    // delay line only moves on accepted samples
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int k = 0; k < pss_pkg::PSS_LEN - 1; k++) begin
                hist_i[k] <= '0;
                hist_q[k] <= '0;
            end
            mag_valid_o <= 1'b0;
        end else begin
            mag_valid_o <= accept;
            if (accept) begin
                for (int k = 0; k < pss_pkg::PSS_LEN - 1; k++) begin
                    hist_i[k] <= win_i[k];
                    hist_q[k] <= win_q[k];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            mag_o <= abs_i + abs_q;
        end
    end

endmodule

/* pss_peak_detector.sv */
`timescale 1ns/100ps

module pss_peak_detector #(
    parameter int WINDOW_LEN = 8
) (
    input  logic                         clk_i,
    input  logic                         reset_ni,
    input  logic [pss_pkg::MAG_W-1:0]    mag_i,
    input  logic                         mag_valid_i,
    input  logic [pss_pkg::MAG_W-1:0]    thresh_i,
    output logic                         peak_o,
    output logic [pss_pkg::MAG_W-1:0]    peak_mag_o
);

    // previous magnitudes, index 0 is the most recent
    logic [pss_pkg::MAG_W-1:0] hist [WINDOW_LEN];

    logic above_all;
    logic above_thresh;

    // strictly larger than everything still in the window
    always_comb begin
        above_all = 1'b1;
        for (int k = 0; k < WINDOW_LEN; k++) begin
            if (mag_i <= hist[k]) begin
                above_all = 1'b0;
            end
        end
    end

    assign above_thresh = (mag_i >= thresh_i);

    // --------------------------------------------------
    // peak flag and window history
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int k = 0; k < WINDOW_LEN; k++) begin
                hist[k] <= '0;
            end
            peak_o <= 1'b0;
        end else begin
            peak_o <= mag_valid_i && above_thresh && above_all;
            if (mag_valid_i) begin
                hist[0] <= mag_i;
                for (int k = 1; k < WINDOW_LEN; k++) begin
                    hist[k] <= hist[k-1];
                end
            end
        end
    end

    // magnitude travels alongside the flag
    always_ff @(posedge clk_i) begin
        if (mag_valid_i) begin
            peak_mag_o <= mag_i;
        end
    end

endmodule

/* pss_decision.sv */
`timescale 1ns/100ps

module pss_decision (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  logic [1:0]                        mode_i,
    input  logic [1:0]                        req_nid2_i,
    input  logic [pss_pkg::NUM_NID2-1:0]      peak_i,
    input  logic [pss_pkg::MAG_W-1:0]         peak_mag0_i,
    input  logic [pss_pkg::MAG_W-1:0]         peak_mag1_i,
    input  logic [pss_pkg::MAG_W-1:0]         peak_mag2_i,
    output logic                              corr_en_o,
    output logic [1:0]                        nid2_o,
    output logic                              nid2_valid_o,
    output logic [pss_pkg::MAG_W-1:0]         win_mag_o
);

    logic                      one_hot;
    logic [1:0]                hit_idx;
    logic [pss_pkg::MAG_W-1:0] hit_mag;
    logic                      hit_ok;
    logic                      run;

    // exactly one candidate fired
    always_comb begin
        one_hot = 1'b1;
        hit_idx = 2'd0;
        hit_mag = peak_mag0_i;
        case (peak_i)
            3'b001: begin
                hit_idx = 2'd0;
                hit_mag = peak_mag0_i;
            end
            3'b010: begin
                hit_idx = 2'd1;
                hit_mag = peak_mag1_i;
            end
            3'b100: begin
                hit_idx = 2'd2;
                hit_mag = peak_mag2_i;
            end
            default: one_hot = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // mode rules
    // --------------------------------------------------
    always_comb begin
        case (mode_i)
            pss_pkg::MODE_SEARCH: hit_ok = one_hot;
            pss_pkg::MODE_FIND:   hit_ok = one_hot && (hit_idx == req_nid2_i);
            default:              hit_ok = 1'b0;
        endcase
    end

    // pause and the spare code 3 freeze the correlators
    assign run = (mode_i == pss_pkg::MODE_SEARCH) || (mode_i == pss_pkg::MODE_FIND);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            corr_en_o    <= 1'b0;
            nid2_valid_o <= 1'b0;
            nid2_o       <= 2'd0;
        end else begin
            corr_en_o    <= run;
            nid2_valid_o <= hit_ok;
            if (hit_ok) begin
                nid2_o <= hit_idx;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (hit_ok) begin
            win_mag_o <= hit_mag;
        end
    end

    assert property (@(posedge clk_i) disable iff (!reset_ni)
        nid2_valid_o |-> (nid2_o < 2'd3));

endmodule

/* pss_apb_regs.sv */
`timescale 1ns/100ps

module pss_apb_regs (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  logic [pss_pkg::APB_ADDR_W-1:0]    paddr_i,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [31:0]                       pwdata_i,
    input  logic [1:0]                        nid2_i,
    input  logic                              nid2_valid_i,
    input  logic [pss_pkg::MAG_W-1:0]         win_mag_i,
    output logic [31:0]                       prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o,
    output logic [1:0]                        mode_o,
    output logic [1:0]                        req_nid2_o,
    output logic [pss_pkg::MAG_W-1:0]         thresh_o
);

    logic                      access;
    logic                      first_access;
    logic                      wr_en;
    logic                      addr_err;
    logic                      read_only;
    logic                      slv_err;
    logic [31:0]               rd_data;

    // status
    logic [15:0]               det_count;
    logic [1:0]                last_nid2;
    logic [pss_pkg::MAG_W-1:0] last_peak;

    assign access       = psel_i && penable_i;
    assign first_access = access && !pready_o;
    // pslverr_o is already known when the write would commit
    assign wr_en        = access && pready_o && pwrite_i && !pslverr_o;

    // --------------------------------------------------
    // address decode and read mux
    // --------------------------------------------------
    always_comb begin
        rd_data   = '0;
        addr_err  = 1'b0;
        read_only = 1'b0;
        case (paddr_i)
            pss_pkg::ADDR_CTRL:   rd_data = {28'd0, req_nid2_o, mode_o};
            pss_pkg::ADDR_THRESH: rd_data = {{(32 - pss_pkg::MAG_W){1'b0}}, thresh_o};
            pss_pkg::ADDR_STATUS: begin
                rd_data   = {8'd0, det_count, 6'd0, last_nid2};
                read_only = 1'b1;
            end
            pss_pkg::ADDR_PEAK: begin
                rd_data   = {{(32 - pss_pkg::MAG_W){1'b0}}, last_peak};
                read_only = 1'b1;
            end
            default: addr_err = 1'b1;
        endcase
    end

    assign slv_err = addr_err || (pwrite_i && read_only);

    // one wait state, response lands on the second access cycle
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pready_o  <= 1'b0;
            pslverr_o <= 1'b0;
        end else begin
            pready_o  <= first_access;
            pslverr_o <= first_access && slv_err;
        end
    end

    always_ff @(posedge clk_i) begin
        if (first_access) begin
            prdata_o <= pwrite_i ? 32'd0 : rd_data;
        end
    end

    // --------------------------------------------------
    // control registers
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            mode_o     <= pss_pkg::MODE_SEARCH;
            req_nid2_o <= 2'd0;
            thresh_o   <= '0;
        end else if (wr_en) begin
            case (paddr_i)
                pss_pkg::ADDR_CTRL: begin
                    mode_o     <= pwdata_i[1:0];
                    req_nid2_o <= pwdata_i[3:2];
                end
                pss_pkg::ADDR_THRESH: thresh_o <= pwdata_i[pss_pkg::MAG_W-1:0];
                default: ;
            endcase
        end
    end

    // detection count wraps
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            det_count <= '0;
            last_nid2 <= 2'd0;
            last_peak <= '0;
        end else if (nid2_valid_i) begin
            det_count <= det_count + 16'd1;
            last_nid2 <= nid2_i;
            last_peak <= win_mag_i;
        end
    end

    assert property (@(posedge clk_i) disable iff (!reset_ni)
        pready_o |-> (psel_i && penable_i));

endmodule

/* pss_detector_top.sv */
`timescale 1ns/100ps

module pss_detector_top #(
    parameter int WINDOW_LEN = 8
) (
    input  logic                                clk_i,
    input  logic                                reset_ni,
    // samples
    input  logic                                sample_valid_i,
    input  logic signed [pss_pkg::SAMPLE_W-1:0] sample_i_i,
    input  logic signed [pss_pkg::SAMPLE_W-1:0] sample_q_i,
    // APB
    input  logic [pss_pkg::APB_ADDR_W-1:0]      paddr_i,
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [31:0]                         pwdata_i,
    output logic [31:0]                         prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    // result
    output logic [1:0]                          nid2_o,
    output logic                                nid2_valid_o
);

    // tap words of all candidates, N_id_2 0 in the low bits
    localparam logic [pss_pkg::NUM_NID2*pss_pkg::PSS_LEN-1:0] TAPS_ALL =
        {pss_pkg::PSS_TAPS_2, pss_pkg::PSS_TAPS_1, pss_pkg::PSS_TAPS_0};

    logic [1:0]                   mode;
    logic [1:0]                   req_nid2;
    logic [pss_pkg::MAG_W-1:0]    thresh;
    logic                         corr_en;
    logic [pss_pkg::MAG_W-1:0]    win_mag;

    logic [pss_pkg::MAG_W-1:0]    mag      [pss_pkg::NUM_NID2];
    logic [pss_pkg::NUM_NID2-1:0] mag_valid;
    logic [pss_pkg::NUM_NID2-1:0] peak;
    logic [pss_pkg::MAG_W-1:0]    peak_mag [pss_pkg::NUM_NID2];

    // --------------------------------------------------
    // one correlator and peak detector per N_id_2
    // --------------------------------------------------
    for (genvar n = 0; n < pss_pkg::NUM_NID2; n++) begin : g_chan
        pss_correlator #(
            .TAPS(TAPS_ALL[n*pss_pkg::PSS_LEN +: pss_pkg::PSS_LEN])
        ) correlator_i (
            .clk_i(clk_i),
            .reset_ni(reset_ni),
            .en_i(corr_en),
            .sample_valid_i(sample_valid_i),
            .sample_i_i(sample_i_i),
            .sample_q_i(sample_q_i),
            .mag_o(mag[n]),
            .mag_valid_o(mag_valid[n])
        );

        pss_peak_detector #(
            .WINDOW_LEN(WINDOW_LEN)
        ) peak_detector_i (
            .clk_i(clk_i),
            .reset_ni(reset_ni),
            .mag_i(mag[n]),
            .mag_valid_i(mag_valid[n]),
            .thresh_i(thresh),
            .peak_o(peak[n]),
            .peak_mag_o(peak_mag[n])
        );
    end

    pss_decision decision_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .mode_i(mode),
        .req_nid2_i(req_nid2),
        .peak_i(peak),
        .peak_mag0_i(peak_mag[0]),
        .peak_mag1_i(peak_mag[1]),
        .peak_mag2_i(peak_mag[2]),
        .corr_en_o(corr_en),
        .nid2_o(nid2_o),
        .nid2_valid_o(nid2_valid_o),
        .win_mag_o(win_mag)
    );

    pss_apb_regs apb_regs_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .paddr_i(paddr_i),
        .psel_i(psel_i),
        .penable_i(penable_i),
        .pwrite_i(pwrite_i),
        .pwdata_i(pwdata_i),
        .nid2_i(nid2_o),
        .nid2_valid_i(nid2_valid_o),
        .win_mag_i(win_mag),
        .prdata_o(prdata_o),
        .pready_o(pready_o),
        .pslverr_o(pslverr_o),
        .mode_o(mode),
        .req_nid2_o(req_nid2),
        .thresh_o(thresh)
    );

endmodule

/* pss_detector_tb.sv */
`timescale 1ns/100ps

module pss_detector_tb;

    // long enough that a copy right after a peak still sees that peak
    localparam int WINDOW_LEN  = 24;
    localparam int APB_TIMEOUT = 20;
    localparam int NOISE_AMP   = 8;

    logic        clk_i = 1'b0;
    logic        reset_ni;
    logic        sample_valid_i;
    logic signed [pss_pkg::SAMPLE_W-1:0] sample_i_i;
    logic signed [pss_pkg::SAMPLE_W-1:0] sample_q_i;
    logic [pss_pkg::APB_ADDR_W-1:0] paddr_i;
    logic        psel_i;
    logic        penable_i;
    logic        pwrite_i;
    logic [31:0] pwdata_i;
    logic [31:0] prdata_o;
    logic        pready_o;
    logic        pslverr_o;
    logic [1:0]  nid2_o;
    logic        nid2_valid_o;

    int seed = 3;
    int errors = 0;
    int checks = 0;
    int neg_count = 0;

    // reference model state, newest sample at index 0
    int line_i [pss_pkg::PSS_LEN];
    int line_q [pss_pkg::PSS_LEN];
    int win_hist [pss_pkg::NUM_NID2][WINDOW_LEN];
    logic [1:0]  model_mode;
    logic [1:0]  model_req;
    int          model_thresh;
    logic [15:0] model_count;
    logic [1:0]  model_last_nid2;
    int          model_last_mag;

    // expected results, due is the negedge count of the nid2_valid_o pulse
    int exp_due[$];
    int exp_nid2[$];
    int exp_mag[$];
    int seen_nid2[int];

    pss_detector_top #(
        .WINDOW_LEN(WINDOW_LEN)
    ) pss_detector_top_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .sample_valid_i(sample_valid_i),
        .sample_i_i(sample_i_i),
        .sample_q_i(sample_q_i),
        .paddr_i(paddr_i),
        .psel_i(psel_i),
        .penable_i(penable_i),
        .pwrite_i(pwrite_i),
        .pwdata_i(pwdata_i),
        .prdata_o(prdata_o),
        .pready_o(pready_o),
        .pslverr_o(pslverr_o),
        .nid2_o(nid2_o),
        .nid2_valid_o(nid2_valid_o)
    );

    always #20 clk_i = ~clk_i;

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [pss_pkg::PSS_LEN-1:0] tap_word(input int n);
        case (n)
            0: return pss_pkg::PSS_TAPS_0;
            1: return pss_pkg::PSS_TAPS_1;
            default: return pss_pkg::PSS_TAPS_2;
        endcase
    endfunction

    // |sum I| + |sum Q| over a full delay line
    function automatic int ref_corr(input int di [pss_pkg::PSS_LEN],
                                    input int dq [pss_pkg::PSS_LEN],
                                    input logic [pss_pkg::PSS_LEN-1:0] taps);
        int si;
        int sq;
        si = 0;
        sq = 0;
        for (int k = 0; k < pss_pkg::PSS_LEN; k++) begin
            si = taps[k] ? si + di[k] : si - di[k];
            sq = taps[k] ? sq + dq[k] : sq - dq[k];
        end
        if (si < 0) si = -si;
        if (sq < 0) sq = -sq;
        return si + sq;
    endfunction

    function automatic int rand_noise();
        return $random(seed) % (NOISE_AMP + 1);
    endfunction

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    task automatic model_sample(input int si, input int sq);
        int   mag;
        int   hits;
        int   idx;
        int   hit_mag;
        logic fire;
        if (model_mode == pss_pkg::MODE_SEARCH || model_mode == pss_pkg::MODE_FIND) begin
            for (int k = pss_pkg::PSS_LEN - 1; k > 0; k--) begin
                line_i[k] = line_i[k-1];
                line_q[k] = line_q[k-1];
            end
            line_i[0] = si;
            line_q[0] = sq;
            hits = 0;
            idx = 0;
            hit_mag = 0;
            for (int n = 0; n < pss_pkg::NUM_NID2; n++) begin
                mag = ref_corr(line_i, line_q, tap_word(n));
                fire = (mag >= model_thresh);
                for (int w = 0; w < WINDOW_LEN; w++) begin
                    if (mag <= win_hist[n][w]) fire = 1'b0;
                end
                for (int w = WINDOW_LEN - 1; w > 0; w--) begin
                    win_hist[n][w] = win_hist[n][w-1];
                end
                win_hist[n][0] = mag;
                if (fire) begin
                    hits++;
                    idx = n;
                    hit_mag = mag;
                end
            end
            // sample accepted next edge, result three edges after that
            if (hits == 1 && (model_mode == pss_pkg::MODE_SEARCH || idx == int'(model_req))) begin
                exp_due.push_back(neg_count + 4);
                exp_nid2.push_back(idx);
                exp_mag.push_back(hit_mag);
                model_count = model_count + 16'd1;
                model_last_nid2 = 2'(idx);
                model_last_mag = hit_mag;
            end
        end
    endtask

    // result monitor, outputs are stable at the falling edge
    always @(negedge clk_i) begin
        neg_count = neg_count + 1;
        if (reset_ni) begin
            if (nid2_valid_o) begin
                seen_nid2[neg_count] = int'(nid2_o);
                if (exp_due.size() == 0) begin
                    $display("N_id_2 %0d reported at cycle %0d with no result expected",
                             nid2_o, neg_count);
                    errors++;
                end else begin
                    check_val("nid2_valid_o cycle", 32'(neg_count), 32'(exp_due.pop_front()));
                    check_val("nid2_o", 32'(nid2_o), 32'(exp_nid2.pop_front()));
                    check_val("win_mag", 32'(pss_detector_top_i.win_mag),
                              32'(exp_mag.pop_front()));
                end
            end else if (exp_due.size() > 0 && exp_due[0] < neg_count) begin
                $display("expected N_id_2 %0d due at cycle %0d never arrived",
                         exp_nid2[0], exp_due[0]);
                errors++;
                void'(exp_due.pop_front());
                void'(exp_nid2.pop_front());
                void'(exp_mag.pop_front());
            end
        end
    end

    // --------------------------------------------------
    // sample stimulus
    // --------------------------------------------------
    task automatic send_sample(input int si, input int sq);
        @(posedge clk_i);
        sample_valid_i <= 1'b1;
        sample_i_i <= si[7:0];
        sample_q_i <= sq[7:0];
        model_sample(si, sq);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            sample_valid_i <= 1'b0;
        end
    endtask

    task automatic send_noise(input int n);
        repeat (n) send_sample(rand_noise(), rand_noise());
    endtask

    // oldest tap first, so tap 0 lands on the newest sample
    task automatic embed_seq(input int seq, input int amp, output int due);
        logic [pss_pkg::PSS_LEN-1:0] taps;
        taps = tap_word(seq);
        for (int k = pss_pkg::PSS_LEN - 1; k >= 0; k--) begin
            send_sample(taps[k] ? amp : -amp, 0);
        end
        due = neg_count + 4;
    endtask

    task automatic expect_hit(input int due, input int nid2);
        if (!seen_nid2.exists(due)) begin
            $display("no result 3 cycles after embedded sequence %0d", nid2);
            errors++;
        end else begin
            check_val("nid2_o after sequence", 32'(seen_nid2[due]), 32'(nid2));
        end
    endtask

    task automatic expect_none(input int due, input int seq);
        if (seen_nid2.exists(due)) begin
            $display("embedded sequence %0d gave a result that should be suppressed", seq);
            errors++;
        end
    endtask

    // --------------------------------------------------
    // APB
    // --------------------------------------------------
    task automatic apb_access(input logic [3:0] addr, input logic write, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int wait_cnt;
        @(posedge clk_i);
        paddr_i <= addr;
        psel_i <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i <= write;
        pwdata_i <= wdata;
        @(posedge clk_i);
        penable_i <= 1'b1;
        wait_cnt = 0;
        @(negedge clk_i);
        while (!pready_o && wait_cnt < APB_TIMEOUT) begin
            @(negedge clk_i);
            wait_cnt++;
        end
        rdata = prdata_o;
        err = pslverr_o;
        if (!pready_o) begin
            $display("APB access to offset 0x%h got no pready_o within %0d cycles",
                     addr, APB_TIMEOUT);
            errors++;
        end
        @(posedge clk_i);
        psel_i <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i <= 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_access(addr, 1'b1, data, rdata, err);
        check_val("pslverr_o on write", 32'(err), 32'd0);
    endtask

    task automatic read_check(input logic [3:0] addr, input logic [31:0] exp, input string name);
        logic [31:0] rdata;
        logic        err;
        apb_access(addr, 1'b0, 32'd0, rdata, err);
        check_val(name, rdata, exp);
        check_val("pslverr_o on read", 32'(err), 32'd0);
    endtask

    task automatic set_mode(input logic [1:0] mode, input logic [1:0] req);
        write_reg(pss_pkg::ADDR_CTRL, {28'd0, req, mode});
        model_mode = mode;
        model_req = req;
        idle(4);
    endtask

    task automatic set_thresh(input int value);
        write_reg(pss_pkg::ADDR_THRESH, 32'(value));
        model_thresh = value;
    endtask

    task automatic check_status();
        read_check(pss_pkg::ADDR_STATUS, {8'd0, model_count, 6'd0, model_last_nid2},
                   "prdata_o STATUS");
        read_check(pss_pkg::ADDR_PEAK, 32'(model_last_mag), "prdata_o PEAK");
    endtask

    initial begin
        int          due;
        int          due_weak;
        logic [31:0] rdata;
        logic        err;

        reset_ni = 1'b0;
        sample_valid_i = 1'b0;
        sample_i_i = '0;
        sample_q_i = '0;
        paddr_i = '0;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        pwdata_i = '0;
        for (int k = 0; k < pss_pkg::PSS_LEN; k++) begin
            line_i[k] = 0;
            line_q[k] = 0;
        end
        for (int n = 0; n < pss_pkg::NUM_NID2; n++) begin
            for (int w = 0; w < WINDOW_LEN; w++) win_hist[n][w] = 0;
        end
        model_mode = pss_pkg::MODE_SEARCH;
        model_req = 2'd0;
        model_thresh = 0;
        model_count = 16'd0;
        model_last_nid2 = 2'd0;
        model_last_mag = 0;

        repeat (5) @(posedge clk_i);
        reset_ni <= 1'b1;
        idle(3);

        // reset values and register access
        read_check(pss_pkg::ADDR_CTRL, 32'd0, "prdata_o CTRL");
        read_check(pss_pkg::ADDR_THRESH, 32'd0, "prdata_o THRESH");
        read_check(pss_pkg::ADDR_STATUS, 32'd0, "prdata_o STATUS");
        read_check(pss_pkg::ADDR_PEAK, 32'd0, "prdata_o PEAK");
        write_reg(pss_pkg::ADDR_CTRL, 32'h0000_0009);
        read_check(pss_pkg::ADDR_CTRL, 32'h0000_0009, "prdata_o CTRL");
        write_reg(pss_pkg::ADDR_THRESH, 32'hFFFF_1234);
        read_check(pss_pkg::ADDR_THRESH, 32'h0000_1234, "prdata_o THRESH");
        apb_access(pss_pkg::ADDR_STATUS, 1'b1, 32'h5, rdata, err);
        check_val("pslverr_o STATUS write", 32'(err), 32'd1);
        apb_access(4'h6, 1'b0, 32'd0, rdata, err);
        check_val("pslverr_o unmapped read", 32'(err), 32'd1);
        read_check(pss_pkg::ADDR_STATUS, 32'd0, "prdata_o STATUS");

        // SEARCH finds every candidate
        set_mode(pss_pkg::MODE_SEARCH, 2'd0);
        set_thresh(400);
        for (int seq = 0; seq < pss_pkg::NUM_NID2; seq++) begin
            send_noise(40);
            embed_seq(seq, 100, due);
            send_noise(10);
            idle(6);
            expect_hit(due, seq);
        end

        // FIND only reports the requested N_id_2
        set_mode(pss_pkg::MODE_FIND, 2'd2);
        for (int seq = 0; seq < pss_pkg::NUM_NID2; seq++) begin
            send_noise(40);
            embed_seq(seq, 100, due);
            send_noise(10);
            idle(6);
            if (seq == 2) expect_hit(due, seq);
            else expect_none(due, seq);
        end

        // PAUSE freezes the delay lines
        set_mode(pss_pkg::MODE_PAUSE, 2'd0);
        send_noise(20);
        embed_seq(1, 100, due);
        idle(6);
        expect_none(due, 1);
        set_mode(pss_pkg::MODE_SEARCH, 2'd0);
        send_noise(40);
        embed_seq(0, 100, due);
        send_noise(10);
        idle(6);
        expect_hit(due, 0);

        check_status();

        // threshold above the full 16 x 100 peak
        set_thresh(1700);
        send_noise(40);
        embed_seq(2, 100, due);
        send_noise(10);
        idle(6);
        expect_none(due, 2);

        // weaker copy while the strong peak is still in the window
        set_thresh(400);
        send_noise(40);
        embed_seq(1, 100, due);
        embed_seq(1, 60, due_weak);
        send_noise(10);
        idle(6);
        expect_hit(due, 1);
        expect_none(due_weak, 1);

        check_status();
        idle(8);
        if (exp_due.size() != 0) begin
            $display("%0d expected results never arrived", exp_due.size());
            errors++;
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* pss_detector.f */
pss_pkg.sv
pss_correlator.sv
pss_peak_detector.sv
pss_decision.sv
pss_apb_regs.sv
pss_detector_top.sv
pss_detector_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the PSS detector testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module pss_detector_tb \
    -f pss_detector.f -o pss_sim &&
./obj_dir/pss_sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no result line in log"; exit 1; }
exit 0
